//--- logic/imager_defines.svh
`ifndef IMAGER_DEFINES_SVH
`define IMAGER_DEFINES_SVH

////////////////////////////////////////////////////////////////////////
// pattern store
////////////////////////////////////////////////////////////////////////
`define MASK_W          10  // one pixel-mask pattern
`define PAT_DEPTH       64  // pattern entries
`define PAT_AW          6   // pattern index width

////////////////////////////////////////////////////////////////////////
// pixel buffer
////////////////////////////////////////////////////////////////////////
`define PIX_W           8   // imager sample
`define WORD_W          24  // three samples per word
`define PIX_FIFO_DEPTH  16
`define PIX_AW          4   // fifo pointer width
`define FRAME_WORDS     8   // frame_ready threshold

// sequencer and timer
`define SUB_W           8
`define TIME_W          16
`define DRAIN_CYCLES    4   // drain_b low time

`endif

//--- logic/imager_pkg.sv
`default_nettype none

`include "imager_defines.svh"

package imager_pkg;

	// sequencer states
	typedef enum logic [2:0] {
		S_IDLE,
		S_PIXRES,  // global pixel reset
		S_MASK,    // mask stream strobe
		S_EXPOSE,
		S_DRAIN,
		S_DONE
	} exp_state_t;

	typedef enum logic {
		TM_EXPOSE,  // subframe window
		TM_DRAIN    // drain period
	} timer_mode_t;

	typedef struct packed {
		logic [`SUB_W-1:0]  num_subframes;
		logic [`TIME_W-1:0] subframe_len;  // expose cycles per subframe
		logic [`TIME_W-1:0] proj_delay;    // trigger offset in window
	} exp_cfg_t;

	typedef struct packed {
		logic pixres_glob;
		logic stream;
		logic drain_b;       // active low
		logic trigger_proj;
		logic exposure_trig;
	} imager_ctrl_t;

	typedef struct packed {
		logic full;
		logic frame_ready;
		logic overflow;  // sticky
	} buf_status_t;

endpackage

`default_nettype wire

//--- logic/pattern_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "imager_defines.svh"

module pattern_store import imager_pkg::*; (
	input  wire                CLK_HS,
	input  wire                reset,
	input  wire                pat_wr,     // host write strobe
	input  wire  [`MASK_W-1:0] pat_data,
	input  wire                pat_clr,    // host clear strobe
	input  wire                busy,       // sequencer running
	input  wire                rd_first,
	input  wire                rd_next,
	output logic [`MASK_W-1:0] mstream,
	output logic               pat_empty
);

	localparam logic [`PAT_AW:0] DEPTH_C = `PAT_DEPTH;

	logic [`MASK_W-1:0] pat_mem [`PAT_DEPTH];
	logic [`PAT_AW-1:0] wr_ptr;
	logic [`PAT_AW:0]   pat_cnt;  // stored patterns 0..PAT_DEPTH
	logic [`PAT_AW-1:0] rd_idx;
	logic [`PAT_AW:0]   rd_inc;
	logic               wr_ok;
	logic               clr_ok;

	// host side locked out while an exposure runs
	assign clr_ok = pat_clr && !busy;
	assign wr_ok  = pat_wr && !busy && !pat_clr && (pat_cnt < DEPTH_C);  // clear wins

	////////////////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_HS) begin
		if (wr_ok) begin
			pat_mem[wr_ptr] <= pat_data;
		end
	end

	always_ff @(posedge CLK_HS) begin
		if (reset || clr_ok) begin
			wr_ptr  <= '0;
			pat_cnt <= '0;
		end else if (wr_ok) begin
			wr_ptr  <= wr_ptr + 1'b1;
			pat_cnt <= pat_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////////////////
	assign rd_inc = {1'b0, rd_idx} + 1'b1;

	// wraps at stored count so patterns repeat
	always_ff @(posedge CLK_HS) begin
		if (reset || rd_first) begin
			rd_idx <= '0;
		end else if (rd_next) begin
			if (rd_inc >= pat_cnt)
				rd_idx <= '0;
			else
				rd_idx <= rd_inc[`PAT_AW-1:0];
		end
	end

	assign mstream   = pat_mem[rd_idx];  // straight from the array
	assign pat_empty = (pat_cnt == '0);

endmodule

`default_nettype wire

//--- logic/subframe_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "imager_defines.svh"

module subframe_timer import imager_pkg::*; (
	input  wire              CLK_HS,
	input  wire              reset,
	input  wire exp_cfg_t    cfg,
	input  wire              timer_load,
	input  wire timer_mode_t timer_mode,
	output logic             expired,   // last cycle of loaded length
	output logic             proj_hit   // projector trigger cycle
);

	localparam logic [`TIME_W-1:0] DRAIN_LEN = `DRAIN_CYCLES;

	logic [`TIME_W-1:0] count;
	logic [`TIME_W-1:0] len_sel;
	logic [`TIME_W-1:0] last_q;   // len - 1
	logic [`TIME_W-1:0] delay_q;
	timer_mode_t        mode_q;
	logic               running;

	assign len_sel = (timer_mode == TM_EXPOSE) ? cfg.subframe_len : DRAIN_LEN;

	// length and delay taken at load, cfg may change between windows
	always_ff @(posedge CLK_HS) begin
		if (timer_load) begin
			last_q  <= (len_sel == '0) ? '0 : len_sel - 1'b1;  // zero acts as one
			delay_q <= cfg.proj_delay;
		end
	end

	always_ff @(posedge CLK_HS) begin
		if (reset) begin
			running <= 1'b0;
			count   <= '0;
			mode_q  <= TM_EXPOSE;
		end else if (timer_load) begin
			running <= 1'b1;
			count   <= '0;  // first counted cycle is the one after load
			mode_q  <= timer_mode;
		end else if (running) begin
			count <= count + 1'b1;
			if (expired)
				running <= 1'b0;
		end
	end

	assign expired  = running && (count == last_q);
	// never reached when delay >= window length
	assign proj_hit = running && (mode_q == TM_EXPOSE) && (count == delay_q);

endmodule

`default_nettype wire

//--- logic/exposure_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "imager_defines.svh"

module exposure_fsm import imager_pkg::*; (
	input  wire              CLK_HS,
	input  wire              reset,
	input  wire              start,
	input  wire exp_cfg_t    cfg,
	input  wire              pat_empty,
	input  wire              expired,
	input  wire              proj_hit,
	output imager_ctrl_t     ctrl,
	output logic             busy,
	output logic             frame_done,
	output logic             rd_first,     // pattern index to 0
	output logic             rd_next,      // advance pattern index
	output logic             timer_load,
	output timer_mode_t      timer_mode
);

	exp_state_t        state;
	exp_state_t        state_n;
	logic [`SUB_W-1:0] sub_cnt;    // subframes done so far
	logic [`SUB_W-1:0] num_sub_q;
	logic [`SUB_W:0]   sub_inc;
	logic              last_sub;
	logic              go;
	logic              pixres_q;
	logic              stream_q;
	logic              drain_b_q;
	logic              expo_q;

	assign go       = (state == S_IDLE) && start && !pat_empty;  // empty store ignored
	assign sub_inc  = {1'b0, sub_cnt} + 1'b1;
	assign last_sub = (sub_inc >= {1'b0, num_sub_q});  // zero runs one subframe

	////////////////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////////////////
	always_comb begin
		state_n = state;
		case (state)
			S_IDLE:   if (go) state_n = S_PIXRES;
			S_PIXRES: state_n = S_MASK;
			S_MASK:   state_n = S_EXPOSE;
			S_EXPOSE: if (expired) state_n = last_sub ? S_DRAIN : S_MASK;
			S_DRAIN:  if (expired) state_n = S_DONE;
			S_DONE:   state_n = S_IDLE;
			default:  state_n = S_IDLE;
		endcase
	end

	// controls registered from the next state, aligned with state
	always_ff @(posedge CLK_HS) begin
		if (reset) begin
			state      <= S_IDLE;
			pixres_q   <= 1'b0;
			stream_q   <= 1'b0;
			drain_b_q  <= 1'b1;  // idle high
			expo_q     <= 1'b0;
			busy       <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			state      <= state_n;
			pixres_q   <= (state_n == S_PIXRES);
			stream_q   <= (state_n == S_MASK);
			drain_b_q  <= (state_n != S_DRAIN);
			expo_q     <= (state_n == S_EXPOSE);
			busy       <= (state_n != S_IDLE);
			frame_done <= (state_n == S_DONE);
		end
	end

	////////////////////////////////////////////////////////////////////////
	// subframe count
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_HS) begin
		if (go)
			num_sub_q <= cfg.num_subframes;  // held for the whole exposure
	end

	always_ff @(posedge CLK_HS) begin
		if (reset || go)
			sub_cnt <= '0;
		else if ((state == S_EXPOSE) && expired)
			sub_cnt <= sub_inc[`SUB_W-1:0];
	end

	// pattern and timer requests
	assign rd_first   = go;
	assign rd_next    = (state == S_MASK);  // after the strobe cycle
	assign timer_load = (state == S_MASK) || ((state == S_EXPOSE) && expired && last_sub);
	assign timer_mode = (state == S_MASK) ? TM_EXPOSE : TM_DRAIN;

	assign ctrl = '{
		pixres_glob:   pixres_q,
		stream:        stream_q,
		drain_b:       drain_b_q,
		trigger_proj:  proj_hit,  // timer already aligned to expose cycle
		exposure_trig: expo_q
	};

endmodule

`default_nettype wire

//--- logic/pixel_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "imager_defines.svh"

module pixel_buffer import imager_pkg::*; (
	input  wire                CLK_HS,
	input  wire                reset,
	input  wire                pix_valid,
	input  wire  [`PIX_W-1:0]  pix_data,
	input  wire                pix_rd,    // pop strobe
	output logic [`WORD_W-1:0] pix_word,  // fifo head
	output logic               pix_empty,
	output buf_status_t        status
);

	localparam logic [`PIX_AW:0] DEPTH_C = `PIX_FIFO_DEPTH;
	localparam logic [`PIX_AW:0] FRAME_C = `FRAME_WORDS;

	logic [1:0]            byte_cnt;  // 0..2
	logic [2*`PIX_W-1:0]   sr;        // first two bytes
	logic [`WORD_W-1:0]    new_word;
	logic                  word_done;
	logic [`WORD_W-1:0]    fifo_mem [`PIX_FIFO_DEPTH];
	logic [`PIX_AW-1:0]    wr_ptr;
	logic [`PIX_AW-1:0]    rd_ptr;
	logic [`PIX_AW:0]      count;
	logic                  full;
	logic                  push;
	logic                  pop;
	logic                  overflow_q;

	////////////////////////////////////////////////////////////////////////
	// 8 to 24 bit packer
	////////////////////////////////////////////////////////////////////////
	assign word_done = pix_valid && (byte_cnt == 2'd2);
	assign new_word  = {pix_data, sr};  // first byte ends up lowest

	always_ff @(posedge CLK_HS) begin
		if (reset)
			byte_cnt <= '0;
		else if (pix_valid)
			byte_cnt <= word_done ? 2'd0 : byte_cnt + 1'b1;
	end

	always_ff @(posedge CLK_HS) begin
		if (pix_valid)
			sr <= {pix_data, sr[2*`PIX_W-1:`PIX_W]};  // shift right
	end

	////////////////////////////////////////////////////////////////////////
	// word fifo, first word falls through
	////////////////////////////////////////////////////////////////////////
	assign full = (count == DEPTH_C);
	assign push = word_done && !full;  // dropped when full
	assign pop  = pix_rd && !pix_empty;

	always_ff @(posedge CLK_HS) begin
		if (push)
			fifo_mem[wr_ptr] <= new_word;
	end

	always_ff @(posedge CLK_HS) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			overflow_q <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // none or both
			endcase
			if (word_done && full)
				overflow_q <= 1'b1;  // held until reset
		end
	end

	assign pix_word  = fifo_mem[rd_ptr];
	assign pix_empty = (count == '0);

	assign status = '{
		full:        full,
		frame_ready: (count >= FRAME_C),
		overflow:    overflow_q
	};

endmodule

`default_nettype wire

//--- logic/imager_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "imager_defines.svh"

module imager_top import imager_pkg::*; (
	input  wire                    CLK_HS,
	input  wire                    reset,
	input  wire exp_cfg_t          cfg,
	input  wire                    start,
	input  wire                    pat_wr,
	input  wire  [`MASK_W-1:0]     pat_data,
	input  wire                    pat_clr,
	input  wire                    pix_valid,
	input  wire  [`PIX_W-1:0]      pix_data,
	input  wire                    pix_rd,
	output wire imager_ctrl_t      ctrl,
	output wire  [`MASK_W-1:0]     mstream,
	output wire                    busy,
	output wire                    frame_done,
	output wire  [`WORD_W-1:0]     pix_word,
	output wire                    pix_empty,
	output wire buf_status_t       status
);

	// sequencer to pattern store
	wire         rd_first;
	wire         rd_next;
	wire         pat_empty;
	// sequencer to timer
	wire         timer_load;
	timer_mode_t timer_mode;
	wire         expired;
	wire         proj_hit;

	////////////////////////////////////////////////////////////////////////
	// mask side
	////////////////////////////////////////////////////////////////////////
	pattern_store u_pattern_store (.CLK_HS(CLK_HS), .reset(reset),
		.pat_wr(pat_wr), .pat_data(pat_data), .pat_clr(pat_clr), .busy(busy),
		.rd_first(rd_first), .rd_next(rd_next),
		.mstream(mstream), .pat_empty(pat_empty));

	subframe_timer u_subframe_timer (.CLK_HS(CLK_HS), .reset(reset), .cfg(cfg),
		.timer_load(timer_load), .timer_mode(timer_mode),
		.expired(expired), .proj_hit(proj_hit));

	exposure_fsm u_exposure_fsm (.CLK_HS(CLK_HS), .reset(reset),
		.start(start), .cfg(cfg), .pat_empty(pat_empty),
		.expired(expired), .proj_hit(proj_hit),
		.ctrl(ctrl), .busy(busy), .frame_done(frame_done),
		.rd_first(rd_first), .rd_next(rd_next),
		.timer_load(timer_load), .timer_mode(timer_mode));

	// pixel side, independent of the sequencer
	pixel_buffer u_pixel_buffer (.CLK_HS(CLK_HS), .reset(reset),
		.pix_valid(pix_valid), .pix_data(pix_data), .pix_rd(pix_rd),
		.pix_word(pix_word), .pix_empty(pix_empty), .status(status));

endmodule

`default_nettype wire

//--- verification/imager_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "imager_defines.svh"

module imager_tb import imager_pkg::*; ();

	localparam int HALF_PERIOD = 50;  // 100 ns clock
	localparam int unsigned SEED = 17;
	// summed cycles of reset, sequence, wrap, trigger, ignored and pixel tests
	localparam int TEST_CYCLES    = 4 + 38 + 40 + 54 + 100 + 104;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic                 CLK_HS;
	logic                 reset;
	exp_cfg_t             cfg;
	logic                 start;
	logic                 pat_wr;
	logic [`MASK_W-1:0]   pat_data;
	logic                 pat_clr;
	logic                 pix_valid;
	logic [`PIX_W-1:0]    pix_data;
	logic                 pix_rd;
	wire imager_ctrl_t    ctrl;
	wire  [`MASK_W-1:0]   mstream;
	wire                  busy;
	wire                  frame_done;
	wire  [`WORD_W-1:0]   pix_word;
	wire                  pix_empty;
	wire buf_status_t     status;

	logic [`MASK_W-1:0]   pats [$];   // stored sequence in load order
	logic [`WORD_W-1:0]   words [$];  // words held in the fifo
	logic                 ovf_model;
	int                   cycle_cnt;

	imager_top UUT (.CLK_HS(CLK_HS), .reset(reset), .cfg(cfg), .start(start),
		.pat_wr(pat_wr), .pat_data(pat_data), .pat_clr(pat_clr),
		.pix_valid(pix_valid), .pix_data(pix_data), .pix_rd(pix_rd),
		.ctrl(ctrl), .mstream(mstream), .busy(busy), .frame_done(frame_done),
		.pix_word(pix_word), .pix_empty(pix_empty), .status(status));

	always #HALF_PERIOD CLK_HS = ~CLK_HS;

	//////////////////////////////////////////////////////////////////////
	// failure reporting and compare tasks
	//////////////////////////////////////////////////////////////////////
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// run limit
	always @(posedge CLK_HS) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYCLES)
			report_failure("Timeout: the tests did not finish in time");
	end

	task automatic check_ctrl(input imager_ctrl_t got, input imager_ctrl_t exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch ctrl at %0t: got %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_mask(input logic [`MASK_W-1:0] got, input logic [`MASK_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch mstream at %0t: got %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_word(input logic [`WORD_W-1:0] got, input logic [`WORD_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch pix_word at %0t: got %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_status(input buf_status_t got, input buf_status_t exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch status at %0t: got %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch %s at %0t: got %h, expected %h",
				name, $time, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// expected behavior from the timing rules
	//////////////////////////////////////////////////////////////////////
	function automatic exp_cfg_t make_cfg(input int nsub, input int len, input int delay);
		exp_cfg_t c;
		c.num_subframes = nsub[`SUB_W-1:0];
		c.subframe_len  = len[`TIME_W-1:0];
		c.proj_delay    = delay[`TIME_W-1:0];
		return c;
	endfunction

	// k counts cycles from the pixel reset pulse
	function automatic imager_ctrl_t expected_ctrl(input exp_cfg_t c, input int k);
		imager_ctrl_t e;
		int len;
		int drain0;
		int pos;
		len    = int'(c.subframe_len);
		drain0 = 1 + int'(c.num_subframes) * (len + 1);
		e         = '0;
		e.drain_b = 1'b1;  // idle level
		if (k == 0) begin
			e.pixres_glob = 1'b1;
		end else if (k < drain0) begin
			pos = (k - 1) % (len + 1);  // 0 is the mask strobe
			if (pos == 0) begin
				e.stream = 1'b1;
			end else begin
				e.exposure_trig = 1'b1;
				// only reachable when delay < len
				if (pos - 1 == int'(c.proj_delay))
					e.trigger_proj = 1'b1;
			end
		end else if (k < drain0 + `DRAIN_CYCLES) begin
			e.drain_b = 1'b0;
		end
		return e;
	endfunction

	function automatic buf_status_t expected_status(input int held, input logic ovf);
		buf_status_t s;
		s.full        = (held == `PIX_FIFO_DEPTH);
		s.frame_ready = (held >= `FRAME_WORDS);
		s.overflow    = ovf;
		return s;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////
	function automatic logic [`MASK_W-1:0] random_pattern();
		logic [31:0] r;
		r = $urandom;
		return r[`MASK_W-1:0];
	endfunction

	task automatic load_pattern(input logic [`MASK_W-1:0] p);
		@(posedge CLK_HS);
		#1;
		pat_wr   = 1'b1;
		pat_data = p;
		@(posedge CLK_HS);
		#1;
		pat_wr = 1'b0;
		pats.push_back(p);
	endtask

	task automatic clear_patterns();
		@(posedge CLK_HS);
		#1;
		pat_clr = 1'b1;
		@(posedge CLK_HS);
		#1;
		pat_clr = 1'b0;
		pats.delete();
	endtask

	// one exposure checked cycle by cycle
	// poke writes a pattern mid-run
	task automatic run_exposure(input exp_cfg_t c, input bit poke);
		int total;
		int len;
		int k;
		imager_ctrl_t e;
		len   = int'(c.subframe_len);
		total = 1 + int'(c.num_subframes) * (len + 1) + `DRAIN_CYCLES + 1;
		@(posedge CLK_HS);
		#1;
		cfg   = c;
		start = 1'b1;
		@(posedge CLK_HS);
		#1;
		start = 1'b0;
		for (k = 0; k <= total; k++) begin
			@(negedge CLK_HS);
			e = expected_ctrl(c, k);
			check_ctrl(ctrl, e);
			check_bit("busy", busy, k < total);
			check_bit("frame_done", frame_done, k == total - 1);
			if (e.stream)
				check_mask(mstream, pats[((k - 1) / (len + 1)) % pats.size()]);
			if (poke && k == 2) begin
				@(posedge CLK_HS);
				#1;
				pat_wr   = 1'b1;
				pat_data = ~pats[0];  // must not reach the store
			end
			if (poke && k == 3) begin
				@(posedge CLK_HS);
				#1;
				pat_wr = 1'b0;
			end
		end
	endtask

	task automatic check_buffer();
		@(negedge CLK_HS);
		check_bit("pix_empty", pix_empty, words.size() == 0);
		check_status(status, expected_status(words.size(), ovf_model));
		if (words.size() != 0)
			check_word(pix_word, words[0]);  // head falls through
	endtask

	task automatic send_word();
		logic [`PIX_W-1:0] b [3];
		logic [31:0] r;
		int i;
		for (i = 0; i < 3; i++) begin
			r    = $urandom;
			b[i] = r[`PIX_W-1:0];
		end
		for (i = 0; i < 3; i++) begin
			@(posedge CLK_HS);
			#1;
			pix_valid = 1'b1;
			pix_data  = b[i];
		end
		@(posedge CLK_HS);
		#1;
		pix_valid = 1'b0;
		if (words.size() < `PIX_FIFO_DEPTH)
			words.push_back({b[2], b[1], b[0]});  // first byte lowest
		else
			ovf_model = 1'b1;
		check_buffer();
	endtask

	task automatic pop_word();
		@(posedge CLK_HS);
		#1;
		pix_rd = 1'b1;
		@(posedge CLK_HS);
		#1;
		pix_rd = 1'b0;
		if (words.size() != 0)
			void'(words.pop_front());  // empty pop ignored
		check_buffer();
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_reset_state();
		@(negedge CLK_HS);
		check_ctrl(ctrl, 5'b00100);  // only drain_b high
		check_bit("busy", busy, 1'b0);
		check_bit("frame_done", frame_done, 1'b0);
		check_bit("pix_empty", pix_empty, 1'b1);
		check_status(status, '0);
	endtask

	task automatic test_pattern_sequence();
		int i;
		for (i = 0; i < 3; i++)
			load_pattern(random_pattern());
		run_exposure(make_cfg(3, 6, 2), 1'b0);
	endtask

	task automatic test_wrap_and_drain();
		clear_patterns();
		load_pattern(random_pattern());
		load_pattern(random_pattern());
		run_exposure(make_cfg(5, 4, 1), 1'b0);  // index i mod 2
	endtask

	task automatic test_projector_trigger();
		run_exposure(make_cfg(3, 5, 3), 1'b0);
		run_exposure(make_cfg(3, 5, 5), 1'b0);  // delay equal to window length gives no pulse
	endtask

	task automatic test_ignored_requests();
		clear_patterns();
		@(posedge CLK_HS);
		#1;
		start = 1'b1;
		@(posedge CLK_HS);
		#1;
		start = 1'b0;
		repeat (50) begin
			@(negedge CLK_HS);
			check_ctrl(ctrl, 5'b00100);
			check_bit("busy", busy, 1'b0);
		end
		load_pattern(random_pattern());
		load_pattern(random_pattern());
		run_exposure(make_cfg(2, 3, 0), 1'b1);
		run_exposure(make_cfg(4, 3, 1), 1'b0);  // a third entry would show at i = 2
	endtask

	task automatic test_pixel_packing();
		int i;
		check_buffer();
		for (i = 0; i < `PIX_FIFO_DEPTH; i++)
			send_word();
		send_word();  // dropped and sets overflow
		for (i = 0; i < `PIX_FIFO_DEPTH; i++)
			pop_word();
		pop_word();
	endtask

	initial begin
		void'($urandom(SEED));
		CLK_HS    = 1'b0;
		reset     = 1'b1;
		cfg       = '0;
		start     = 1'b0;
		pat_wr    = 1'b0;
		pat_data  = '0;
		pat_clr   = 1'b0;
		pix_valid = 1'b0;
		pix_data  = '0;
		pix_rd    = 1'b0;
		ovf_model = 1'b0;
		cycle_cnt = 0;
		repeat (2) @(posedge CLK_HS);
		#1;
		reset = 1'b0;
		test_reset_state();
		test_pattern_sequence();
		test_wrap_and_drain();
		test_projector_trigger();
		test_ignored_requests();
		test_pixel_packing();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- imager_top.f
+incdir+logic
logic/imager_pkg.sv
logic/pattern_store.sv
logic/subframe_timer.sv
logic/exposure_fsm.sv
logic/pixel_buffer.sv
logic/imager_top.sv
verification/imager_tb.sv

//--- Makefile
# Verilator simulation of the imager control core

VERILATOR ?= verilator
TOP       ?= imager_tb
FILELIST  ?= imager_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
